// ==== common/periph_xbar_pkg.sv ====
//######################################
// Peripheral crossbar package
// Bus widths, port counts, cluster address
// map and the shared vector types
//######################################

`default_nettype none

package periph_xbar_pkg;

  // Port counts
  localparam int unsigned NB_MASTERS = 4;
  localparam int unsigned NB_TARGETS = 4;

  // Bus widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  // Index widths derived from the counts
  localparam int unsigned MST_IDX_WIDTH = $clog2(NB_MASTERS);
  localparam int unsigned TGT_IDX_WIDTH = $clog2(NB_TARGETS);

  // Payload vectors
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [BE_WIDTH-1:0]   be_t;

  // One-hot initiator id, bit k set means initiator k
  typedef logic [NB_MASTERS-1:0] mst_id_t;

  // One bit per initiator
  typedef logic [NB_MASTERS-1:0] mst_vec_t;

  // Binary initiator index, used by the round-robin pointer
  typedef logic [MST_IDX_WIDTH-1:0] mst_idx_t;

  // Binary target index
  typedef logic [TGT_IDX_WIDTH-1:0] tgt_idx_t;

  // Cluster address map, top byte of the address
  localparam logic [7:0] CLUSTER_BASE       = 8'h10;
  localparam logic       CLUSTER_ALIAS_EN   = 1'b1;
  localparam logic [7:0] CLUSTER_ALIAS_BASE = 8'h1B;

  // Peripheral window on address bits 23 to 20
  localparam logic [3:0] PERIPH_WIN_LO = 4'h2;
  localparam logic [3:0] PERIPH_WIN_HI = 4'h3;

  // Address bits that pick the target inside the window
  localparam int unsigned ROUTE_LSB = 16;
  localparam int unsigned ROUTE_MSB = 17;

  // Every address outside the window goes here
  localparam tgt_idx_t TGT_EXT_IDX = tgt_idx_t'(0);

endpackage : periph_xbar_pkg

`default_nettype wire

// ==== hdl/periph_addr_decode.sv ====
//######################################
// Peripheral address decoder
// Picks a target for each initiator and
// steers requests and grants between the
// initiators and the target arbiters
//######################################

`default_nettype none

module periph_addr_decode
  import periph_xbar_pkg::*;
(
  input  mst_vec_t                   mst_req_i,
  input  addr_t    [NB_MASTERS-1:0]  mst_addr_i,
  input  mst_vec_t [NB_TARGETS-1:0]  arb_gnt_i,
  output mst_vec_t [NB_TARGETS-1:0]  arb_req_o,
  output mst_vec_t                   mst_gnt_o
);

  // Target chosen by each initiator's address
  tgt_idx_t [NB_MASTERS-1:0] tgt_sel;

  // Cluster peripheral window, everything else is external
  function automatic tgt_idx_t addr_to_tgt(input addr_t addr);
    logic in_cluster;
    logic in_alias;
    logic in_window;

    in_cluster = (addr[31:24] == CLUSTER_BASE);
    // Alias base only counts when enabled
    in_alias   = CLUSTER_ALIAS_EN && (addr[31:24] == CLUSTER_ALIAS_BASE);
    in_window  = (addr[23:20] >= PERIPH_WIN_LO) && (addr[23:20] <= PERIPH_WIN_HI);

    if ((in_cluster || in_alias) && in_window) begin
      return tgt_idx_t'(addr[ROUTE_MSB:ROUTE_LSB]);
    end else begin
      return TGT_EXT_IDX;
    end
  endfunction

  always_comb begin
    for (int m = 0; m < NB_MASTERS; m++) begin
      tgt_sel[m] = addr_to_tgt(mst_addr_i[m]);
    end
  end

  // Request only reaches the arbiter of the selected target
  always_comb begin
    for (int t = 0; t < NB_TARGETS; t++) begin
      for (int m = 0; m < NB_MASTERS; m++) begin
        arb_req_o[t][m] = mst_req_i[m] && (tgt_sel[m] == tgt_idx_t'(t));
      end
    end
  end

  // Grant comes back from that same arbiter
  always_comb begin
    mst_gnt_o = '0;
    for (int m = 0; m < NB_MASTERS; m++) begin
      for (int t = 0; t < NB_TARGETS; t++) begin
        if (tgt_sel[m] == tgt_idx_t'(t)) begin
          mst_gnt_o[m] = arb_gnt_i[t][m];
        end
      end
    end
  end

endmodule : periph_addr_decode

`default_nettype wire

// ==== hdl/periph_resp_router.sv ====
//######################################
// Response router
// Sends each target response back to the
// initiator named by its one-hot id
//######################################

`default_nettype none

module periph_resp_router
  import periph_xbar_pkg::*;
(
  input  logic    [NB_TARGETS-1:0]  tgt_r_valid_i,
  input  mst_id_t [NB_TARGETS-1:0]  tgt_r_id_i,
  input  data_t   [NB_TARGETS-1:0]  tgt_r_rdata_i,
  input  logic    [NB_TARGETS-1:0]  tgt_r_opc_i,
  output mst_vec_t                  mst_r_valid_o,
  output data_t   [NB_MASTERS-1:0]  mst_r_rdata_o,
  output mst_vec_t                  mst_r_opc_o
);

  // Which target responses are addressed to which initiator
  logic [NB_MASTERS-1:0][NB_TARGETS-1:0] hit;

  always_comb begin
    for (int m = 0; m < NB_MASTERS; m++) begin
      for (int t = 0; t < NB_TARGETS; t++) begin
        hit[m][t] = tgt_r_valid_i[t] && tgt_r_id_i[t][m];
      end
    end
  end

  // Lowest-index target wins, outputs stay zero without a hit
  always_comb begin
    mst_r_valid_o = '0;
    mst_r_rdata_o = '0;
    mst_r_opc_o   = '0;
    for (int m = 0; m < NB_MASTERS; m++) begin
      for (int t = NB_TARGETS - 1; t >= 0; t--) begin
        if (hit[m][t]) begin
          mst_r_valid_o[m] = 1'b1;
          mst_r_rdata_o[m] = tgt_r_rdata_i[t];
          mst_r_opc_o[m]   = tgt_r_opc_i[t];
        end
      end
    end
  end

endmodule : periph_resp_router

`default_nettype wire

// ==== hdl/periph_xbar.sv ====
//######################################
// Peripheral crossbar top level
// Four initiators to four peripheral targets
// over a request/grant bus, with responses
// routed back by one-hot initiator id
//######################################

`default_nettype none

module periph_xbar
  import periph_xbar_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  // Initiator side
  input  mst_vec_t                   mst_req_i,
  input  addr_t   [NB_MASTERS-1:0]   mst_addr_i,
  input  mst_vec_t                   mst_wen_n_i,
  input  data_t   [NB_MASTERS-1:0]   mst_wdata_i,
  input  be_t     [NB_MASTERS-1:0]   mst_be_i,
  output mst_vec_t                   mst_gnt_o,
  output mst_vec_t                   mst_r_valid_o,
  output data_t   [NB_MASTERS-1:0]   mst_r_rdata_o,
  output mst_vec_t                   mst_r_opc_o,

  // Target side
  output logic    [NB_TARGETS-1:0]   tgt_req_o,
  output addr_t   [NB_TARGETS-1:0]   tgt_addr_o,
  output logic    [NB_TARGETS-1:0]   tgt_wen_n_o,
  output data_t   [NB_TARGETS-1:0]   tgt_wdata_o,
  output be_t     [NB_TARGETS-1:0]   tgt_be_o,
  output mst_id_t [NB_TARGETS-1:0]   tgt_id_o,
  input  logic    [NB_TARGETS-1:0]   tgt_gnt_i,
  input  logic    [NB_TARGETS-1:0]   tgt_r_valid_i,
  input  mst_id_t [NB_TARGETS-1:0]   tgt_r_id_i,
  input  data_t   [NB_TARGETS-1:0]   tgt_r_rdata_i,
  input  logic    [NB_TARGETS-1:0]   tgt_r_opc_i
);

  // Per-target request and grant vectors between decoder and arbiters
  mst_vec_t [NB_TARGETS-1:0] arb_req;
  mst_vec_t [NB_TARGETS-1:0] arb_gnt;

  periph_addr_decode i_addr_decode (
    .mst_req_i  (mst_req_i),
    .mst_addr_i (mst_addr_i),
    .arb_gnt_i  (arb_gnt),
    .arb_req_o  (arb_req),
    .mst_gnt_o  (mst_gnt_o)
  );

  // One round-robin arbiter in front of each target
  for (genvar t = 0; t < NB_TARGETS; t++) begin : gen_tgt_arb
    periph_target_arb i_target_arb (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (arb_req[t]),
      .mst_addr_i  (mst_addr_i),
      .mst_wen_n_i (mst_wen_n_i),
      .mst_wdata_i (mst_wdata_i),
      .mst_be_i    (mst_be_i),
      .gnt_o       (arb_gnt[t]),
      .tgt_req_o   (tgt_req_o[t]),
      .tgt_addr_o  (tgt_addr_o[t]),
      .tgt_wen_n_o (tgt_wen_n_o[t]),
      .tgt_wdata_o (tgt_wdata_o[t]),
      .tgt_be_o    (tgt_be_o[t]),
      .tgt_id_o    (tgt_id_o[t]),
      .tgt_gnt_i   (tgt_gnt_i[t])
    );
  end

  // Responses go back by id, no back-pressure
  periph_resp_router i_resp_router (
    .tgt_r_valid_i (tgt_r_valid_i),
    .tgt_r_id_i    (tgt_r_id_i),
    .tgt_r_rdata_i (tgt_r_rdata_i),
    .tgt_r_opc_i   (tgt_r_opc_i),
    .mst_r_valid_o (mst_r_valid_o),
    .mst_r_rdata_o (mst_r_rdata_o),
    .mst_r_opc_o   (mst_r_opc_o)
  );

endmodule : periph_xbar

`default_nettype wire

// ==== periph_arb/periph_target_arb.sv ====
//######################################
// Target arbiter
// Round-robin choice between initiators
// and request multiplexer for one target
//######################################

`default_nettype none

module periph_target_arb
  import periph_xbar_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // From the decoder, one request bit per initiator
  input  mst_vec_t                 req_i,
  input  addr_t   [NB_MASTERS-1:0] mst_addr_i,
  input  mst_vec_t                 mst_wen_n_i,
  input  data_t   [NB_MASTERS-1:0] mst_wdata_i,
  input  be_t     [NB_MASTERS-1:0] mst_be_i,
  output mst_vec_t                 gnt_o,

  // Toward the target
  output logic                     tgt_req_o,
  output addr_t                    tgt_addr_o,
  output logic                     tgt_wen_n_o,
  output data_t                    tgt_wdata_o,
  output be_t                      tgt_be_o,
  output mst_id_t                  tgt_id_o,
  input  logic                     tgt_gnt_i
);

  // Initiator with the highest priority this cycle
  mst_idx_t rr_ptr;

  logic     sel_valid;
  mst_idx_t sel_idx;
  mst_id_t  sel_onehot;
  logic     accept;

  // First requester at or above the pointer, wrapping around
  always_comb begin
    int unsigned cand;

    sel_valid = 1'b0;
    sel_idx   = rr_ptr;
    for (int unsigned off = 0; off < NB_MASTERS; off++) begin
      cand = (int'(rr_ptr) + off) % NB_MASTERS;
      if (!sel_valid && req_i[cand]) begin
        sel_valid = 1'b1;
        sel_idx   = mst_idx_t'(cand);
      end
    end
  end

  assign sel_onehot = sel_valid ? (mst_id_t'(1) << sel_idx) : '0;

  // Chosen request stays visible under back-pressure
  assign tgt_req_o   = sel_valid;
  assign tgt_addr_o  = mst_addr_i[sel_idx];
  assign tgt_wen_n_o = mst_wen_n_i[sel_idx];
  assign tgt_wdata_o = mst_wdata_i[sel_idx];
  assign tgt_be_o    = mst_be_i[sel_idx];
  assign tgt_id_o    = sel_onehot;

  // Grant only when the target takes it
  assign accept = sel_valid && tgt_gnt_i;
  assign gnt_o  = accept ? sel_onehot : '0;

  // Pointer moves past the winner after each handshake
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr <= '0;
    end else if (accept) begin
      rr_ptr <= mst_idx_t'((int'(sel_idx) + 1) % NB_MASTERS);
    end
  end

endmodule : periph_target_arb

`default_nettype wire

// ==== periph_xbar.f ====
common/periph_xbar_pkg.sv
hdl/periph_addr_decode.sv
periph_arb/periph_target_arb.sv
hdl/periph_resp_router.sv
hdl/periph_xbar.sv
verif/periph_xbar_props.sv
verif/tb_periph_xbar.sv

// ==== verif/periph_xbar_props.sv ====
//########################################
// Crossbar bus properties
// Target request held under back-pressure
// and grants only for live requests
//########################################

`default_nettype none

module periph_xbar_props
  import periph_xbar_pkg::*;
(
  input logic                      clk_i,
  input logic                      rst_n_i,
  input mst_vec_t                  mst_req_i,
  input mst_vec_t                  mst_gnt_o,
  input logic    [NB_TARGETS-1:0]  tgt_req_o,
  input addr_t   [NB_TARGETS-1:0]  tgt_addr_o,
  input logic    [NB_TARGETS-1:0]  tgt_wen_n_o,
  input data_t   [NB_TARGETS-1:0]  tgt_wdata_o,
  input be_t     [NB_TARGETS-1:0]  tgt_be_o,
  input mst_id_t [NB_TARGETS-1:0]  tgt_id_o,
  input logic    [NB_TARGETS-1:0]  tgt_gnt_i
);

  // Set by any property failure
  logic prop_fail = 1'b0;

  // A waiting request keeps its payload until the target takes it
  for (genvar t = 0; t < NB_TARGETS; t++) begin : gen_tgt
    a_req_stable : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (tgt_req_o[t] && !tgt_gnt_i[t]) |=>
        (tgt_req_o[t] && $stable(tgt_id_o[t]) && $stable(tgt_addr_o[t]) &&
         $stable(tgt_wen_n_o[t]) && $stable(tgt_wdata_o[t]) && $stable(tgt_be_o[t]))
    ) else begin
      prop_fail = 1'b1;
      $error("Target %0d request changed before its grant", t);
    end
  end

  a_gnt_has_req : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (mst_gnt_o & ~mst_req_i) == '0
  ) else begin
    prop_fail = 1'b1;
    $error("Initiator granted without a request");
  end

endmodule : periph_xbar_props

`default_nettype wire

// ==== verif/tb_periph_xbar.sv ====
//########################################
// Peripheral crossbar testbench
// Directed tests for decode, forwarding,
// round robin, back-pressure, responses
//########################################

`default_nettype none

module tb_periph_xbar
  import periph_xbar_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int SETTLE       = 2;
  localparam int RESET_CYCLES = 5;
  localparam int GNT_WAIT_MAX = 8;
  // Six tests, each a reset plus at most 40 cycles of traffic
  localparam int NUM_TESTS       = 6;
  localparam int TEST_BUDGET     = 40;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (RESET_CYCLES + 1 + TEST_BUDGET) + 20;

  logic                      clk;
  logic                      rst_n;
  mst_vec_t                  mst_req;
  addr_t   [NB_MASTERS-1:0]  mst_addr;
  mst_vec_t                  mst_wen_n;
  data_t   [NB_MASTERS-1:0]  mst_wdata;
  be_t     [NB_MASTERS-1:0]  mst_be;
  mst_vec_t                  mst_gnt;
  mst_vec_t                  mst_r_valid;
  data_t   [NB_MASTERS-1:0]  mst_r_rdata;
  mst_vec_t                  mst_r_opc;
  logic    [NB_TARGETS-1:0]  tgt_req;
  addr_t   [NB_TARGETS-1:0]  tgt_addr;
  logic    [NB_TARGETS-1:0]  tgt_wen_n;
  data_t   [NB_TARGETS-1:0]  tgt_wdata;
  be_t     [NB_TARGETS-1:0]  tgt_be;
  mst_id_t [NB_TARGETS-1:0]  tgt_id;
  logic    [NB_TARGETS-1:0]  tgt_gnt;
  logic    [NB_TARGETS-1:0]  tgt_r_valid;
  mst_id_t [NB_TARGETS-1:0]  tgt_r_id;
  data_t   [NB_TARGETS-1:0]  tgt_r_rdata;
  logic    [NB_TARGETS-1:0]  tgt_r_opc;

  periph_xbar uut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .mst_req_i     (mst_req),
    .mst_addr_i    (mst_addr),
    .mst_wen_n_i   (mst_wen_n),
    .mst_wdata_i   (mst_wdata),
    .mst_be_i      (mst_be),
    .mst_gnt_o     (mst_gnt),
    .mst_r_valid_o (mst_r_valid),
    .mst_r_rdata_o (mst_r_rdata),
    .mst_r_opc_o   (mst_r_opc),
    .tgt_req_o     (tgt_req),
    .tgt_addr_o    (tgt_addr),
    .tgt_wen_n_o   (tgt_wen_n),
    .tgt_wdata_o   (tgt_wdata),
    .tgt_be_o      (tgt_be),
    .tgt_id_o      (tgt_id),
    .tgt_gnt_i     (tgt_gnt),
    .tgt_r_valid_i (tgt_r_valid),
    .tgt_r_id_i    (tgt_r_id),
    .tgt_r_rdata_i (tgt_r_rdata),
    .tgt_r_opc_i   (tgt_r_opc)
  );

  bind periph_xbar periph_xbar_props i_props (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mst_req_i   (mst_req_i),
    .mst_gnt_o   (mst_gnt_o),
    .tgt_req_o   (tgt_req_o),
    .tgt_addr_o  (tgt_addr_o),
    .tgt_wen_n_o (tgt_wen_n_o),
    .tgt_wdata_o (tgt_wdata_o),
    .tgt_be_o    (tgt_be_o),
    .tgt_id_o    (tgt_id_o),
    .tgt_gnt_i   (tgt_gnt_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_run();
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_vec(input string name, input mst_vec_t exp, input mst_vec_t act);
    if (act !== exp) begin
      $display("Fail time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic compare_id(input string name, input mst_id_t exp, input mst_id_t act);
    if (act !== exp) begin
      $display("Fail time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic compare_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic init_inputs();
    clk         = 1'b0;
    rst_n       = 1'b0;
    mst_req     = '0;
    mst_addr    = '0;
    mst_wen_n   = '1;
    mst_wdata   = '0;
    mst_be      = '0;
    tgt_gnt     = '0;
    tgt_r_valid = '0;
    tgt_r_id    = '0;
    tgt_r_rdata = '0;
    tgt_r_opc   = '0;
  endtask

  // Clears the round-robin pointers between tests
  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic drive_req(input int m, input addr_t addr, input logic wen_n);
    mst_req[m]   = 1'b1;
    mst_addr[m]  = addr;
    mst_wen_n[m] = wen_n;
    mst_wdata[m] = $urandom();
    mst_be[m]    = be_t'($urandom());
  endtask

  // Returns in the cycle where initiator m sees its grant
  task automatic wait_grant(input int m);
    int n;

    n = 0;
    #(SETTLE);
    while (!mst_gnt[m]) begin
      n++;
      if (n > GNT_WAIT_MAX) begin
        $display("Initiator %0d was never granted", m);
        fail_run();
      end
      @(negedge clk);
      #(SETTLE);
    end
  endtask

  task automatic check_route(input int m, input addr_t addr, input tgt_idx_t exp_tgt);
    @(negedge clk);
    drive_req(m, addr, 1'b1);
    wait_grant(m);
    compare_vec("tgt_req_o", mst_vec_t'(1) << exp_tgt, mst_vec_t'(tgt_req));
    compare_addr($sformatf("tgt_addr_o[%0d]", exp_tgt), addr, tgt_addr[exp_tgt]);
    @(negedge clk);
    mst_req[m] = 1'b0;
  endtask

  task automatic test_decode();
    apply_reset();
    tgt_gnt = '1;
    check_route(0, 32'h1020_0000, 2'd0);
    check_route(1, 32'h1021_0004, 2'd1);
    check_route(2, 32'h1032_0008, 2'd2);
    check_route(3, 32'h1023_000C, 2'd3);
    // Alias top byte
    check_route(0, 32'h1B33_0010, 2'd3);
    check_route(1, 32'h1B22_0000, 2'd2);
    // Outside the window or the cluster go external
    check_route(2, 32'h1013_0000, 2'd0);
    check_route(3, 32'h1043_0000, 2'd0);
    check_route(0, 32'h2023_0000, 2'd0);
    check_route(1, 32'h1A21_0000, 2'd0);
    tgt_gnt = '0;
  endtask

  task automatic test_forward();
    addr_t addr;

    apply_reset();
    addr    = 32'h1022_0040;
    tgt_gnt = '1;
    drive_req(2, addr, 1'b0);
    #(SETTLE);
    compare_vec("tgt_req_o", 4'b0100, tgt_req);
    compare_addr("tgt_addr_o[2]", addr, tgt_addr[2]);
    compare_vec("tgt_wen_n_o[2]", '0, mst_vec_t'(tgt_wen_n[2]));
    compare_data("tgt_wdata_o[2]", mst_wdata[2], tgt_wdata[2]);
    compare_data("tgt_be_o[2]", data_t'(mst_be[2]), data_t'(tgt_be[2]));
    compare_id("tgt_id_o[2]", 4'b0100, tgt_id[2]);
    compare_vec("mst_gnt_o", 4'b0100, mst_gnt);
    @(negedge clk);
    mst_req[2] = 1'b0;
    tgt_gnt    = '0;
  endtask

  task automatic request_all(input addr_t base);
    for (int m = 0; m < NB_MASTERS; m++) begin
      drive_req(m, base + addr_t'(4 * m), 1'b1);
    end
  endtask

  // One grant per cycle on target 1, in rotating order from first
  task automatic serve_in_order(input int first);
    int k;

    for (int n = 0; n < NB_MASTERS; n++) begin
      k = (first + n) % NB_MASTERS;
      #(SETTLE);
      compare_vec("mst_gnt_o", mst_vec_t'(1) << k, mst_gnt);
      compare_id("tgt_id_o[1]", mst_id_t'(1) << k, tgt_id[1]);
      @(negedge clk);
      mst_req[k] = 1'b0;
    end
  endtask

  task automatic test_round_robin();
    apply_reset();
    tgt_gnt = 4'b0010;
    request_all(32'h1021_0000);
    serve_in_order(0);
    // Lone initiator 1 leaves initiator 2 next in line
    drive_req(1, 32'h1021_0100, 1'b1);
    #(SETTLE);
    compare_vec("mst_gnt_o", 4'b0010, mst_gnt);
    @(negedge clk);
    mst_req[1] = 1'b0;
    request_all(32'h1021_0000);
    serve_in_order(2);
    tgt_gnt = '0;
  endtask

  task automatic test_back_pressure();
    addr_t addr1;

    apply_reset();
    addr1   = 32'h1033_0010;
    tgt_gnt = '0;
    drive_req(1, addr1, 1'b0);
    drive_req(3, 32'h1033_0030, 1'b1);
    repeat (3) begin
      #(SETTLE);
      compare_vec("mst_gnt_o", '0, mst_gnt);
      compare_vec("tgt_req_o", 4'b1000, tgt_req);
      compare_id("tgt_id_o[3]", 4'b0010, tgt_id[3]);
      compare_addr("tgt_addr_o[3]", addr1, tgt_addr[3]);
      @(negedge clk);
    end
    tgt_gnt[3] = 1'b1;
    wait_grant(1);
    compare_vec("mst_gnt_o", 4'b0010, mst_gnt);
    @(negedge clk);
    mst_req[1] = 1'b0;
    wait_grant(3);
    compare_vec("mst_gnt_o", 4'b1000, mst_gnt);
    compare_id("tgt_id_o[3]", 4'b1000, tgt_id[3]);
    @(negedge clk);
    mst_req[3] = 1'b0;
    tgt_gnt    = '0;
  endtask

  task automatic send_responses(input logic [NB_TARGETS-1:0] valid,
                                input mst_id_t [NB_TARGETS-1:0] ids);
    mst_vec_t                exp_valid;
    mst_vec_t                exp_opc;
    data_t [NB_MASTERS-1:0]  exp_rdata;

    @(negedge clk);
    tgt_r_valid = valid;
    tgt_r_id    = ids;
    for (int t = 0; t < NB_TARGETS; t++) begin
      tgt_r_rdata[t] = $urandom();
      tgt_r_opc[t]   = 1'($urandom());
    end
    exp_valid = '0;
    exp_opc   = '0;
    exp_rdata = '0;
    // The lowest target that names an initiator answers it
    for (int m = 0; m < NB_MASTERS; m++) begin
      for (int t = 0; t < NB_TARGETS; t++) begin
        if (!exp_valid[m] && valid[t] && ids[t][m]) begin
          exp_valid[m] = 1'b1;
          exp_rdata[m] = tgt_r_rdata[t];
          exp_opc[m]   = tgt_r_opc[t];
        end
      end
    end
    #(SETTLE);
    compare_vec("mst_r_valid_o", exp_valid, mst_r_valid);
    compare_vec("mst_r_opc_o", exp_opc, mst_r_opc);
    for (int m = 0; m < NB_MASTERS; m++) begin
      compare_data($sformatf("mst_r_rdata_o[%0d]", m), exp_rdata[m], mst_r_rdata[m]);
    end
    @(negedge clk);
    tgt_r_valid = '0;
  endtask

  task automatic test_responses();
    apply_reset();
    // Target 2 idle but carrying a stale id
    send_responses(4'b1011, {4'b1000, 4'b0010, 4'b0001, 4'b0100});
    send_responses(4'b0110, {4'b0001, 4'b1000, 4'b0010, 4'b0100});
    // Targets 1 and 3 both answer initiator 0 in the same cycle
    send_responses(4'b1111, {4'b0001, 4'b0100, 4'b0001, 4'b1000});
  endtask

  task automatic test_parallel();
    apply_reset();
    tgt_gnt = '1;
    drive_req(0, 32'h1023_0000, 1'b1);
    drive_req(1, 32'h1B32_0004, 1'b0);
    drive_req(2, 32'h1021_0008, 1'b1);
    drive_req(3, 32'h4000_000C, 1'b0);
    #(SETTLE);
    compare_vec("mst_gnt_o", 4'b1111, mst_gnt);
    compare_vec("tgt_req_o", 4'b1111, tgt_req);
    compare_id("tgt_id_o[0]", 4'b1000, tgt_id[0]);
    compare_id("tgt_id_o[1]", 4'b0100, tgt_id[1]);
    compare_id("tgt_id_o[2]", 4'b0010, tgt_id[2]);
    compare_id("tgt_id_o[3]", 4'b0001, tgt_id[3]);
    @(negedge clk);
    mst_req = '0;
    tgt_gnt = '0;
  endtask

  initial begin
    void'($urandom(32'h4720));
    init_inputs();
    test_decode();
    test_forward();
    test_round_robin();
    test_back_pressure();
    test_responses();
    test_parallel();
    @(negedge clk);
    if (uut.i_props.prop_fail) begin
      $display("A bus property assertion failed");
      fail_run();
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (uut.i_props.prop_fail) begin
      $display("A bus property assertion failed");
      fail_run();
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    fail_run();
  end

endmodule : tb_periph_xbar

`default_nettype wire
